// ==== cache_hier.f ====
src/cache_pkg.sv
src/line_store.sv
src/l1_cache.sv
src/l1_arbiter.sv
src/l2_cache.sv
src/cache_hier.sv
verif/mem_model.sv
verif/cache_hier_tb.sv

// ==== src/cache_hier.sv ====
`timescale 1ns/1ps

module cache_hier
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   // Processor port
   input  logic              i_valid,
   input  logic              i_instr,                     // Selects the instruction L1
   input  cache_req_t        i_req,
   output logic              o_ready,
   output logic [DATA_W-1:0] o_rdata,
   // Native memory port
   output logic              o_mem_valid,
   output cache_req_t        o_mem_req,
   input  logic              i_mem_ready,
   input  logic [DATA_W-1:0] i_mem_rdata
);

   logic              instr_valid;
   logic              data_valid;
   logic              l1i_ready;
   logic [DATA_W-1:0] l1i_rdata;
   logic              l1d_ready;
   logic [DATA_W-1:0] l1d_rdata;
   logic              l1i_mem_valid;                      // L1 miss streams
   cache_req_t        l1i_mem_req;
   logic              l1i_mem_ready;
   logic              l1d_mem_valid;
   cache_req_t        l1d_mem_req;
   logic              l1d_mem_ready;
   logic              l2_valid;                           // Merged stream into L2
   cache_req_t        l2_req;
   logic              l2_ready;
   logic [DATA_W-1:0] l2_rdata;

   ////////////////////////////////////////////////////////////
   // Port split and response merge
   ////////////////////////////////////////////////////////////
   assign instr_valid = i_valid && i_instr;
   assign data_valid  = i_valid && !i_instr;
   assign o_ready     = l1i_ready | l1d_ready;
   assign o_rdata     = l1d_ready ? l1d_rdata : l1i_rdata;

   l1_cache #(.IS_INSTR(1'b1)) l1_i (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (instr_valid),
      .i_req       (i_req),
      .o_ready     (l1i_ready),
      .o_rdata     (l1i_rdata),
      .o_mem_valid (l1i_mem_valid),
      .o_mem_req   (l1i_mem_req),
      .i_mem_ready (l1i_mem_ready),
      .i_mem_rdata (l2_rdata)                             // Taken only by the owner
   );

   l1_cache #(.IS_INSTR(1'b0)) l1_d (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (data_valid),
      .i_req       (i_req),
      .o_ready     (l1d_ready),
      .o_rdata     (l1d_rdata),
      .o_mem_valid (l1d_mem_valid),
      .o_mem_req   (l1d_mem_req),
      .i_mem_ready (l1d_mem_ready),
      .i_mem_rdata (l2_rdata)
   );

   l1_arbiter u_arb (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_i_valid  (l1i_mem_valid),
      .i_i_req    (l1i_mem_req),
      .o_i_ready  (l1i_mem_ready),
      .i_d_valid  (l1d_mem_valid),
      .i_d_req    (l1d_mem_req),
      .o_d_ready  (l1d_mem_ready),
      .o_l2_valid (l2_valid),
      .o_l2_req   (l2_req),
      .i_l2_ready (l2_ready)
   );

   l2_cache u_l2 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (l2_valid),
      .i_req       (l2_req),
      .o_ready     (l2_ready),
      .o_rdata     (l2_rdata),
      .o_mem_valid (o_mem_valid),
      .o_mem_req   (o_mem_req),
      .i_mem_ready (i_mem_ready),
      .i_mem_rdata (i_mem_rdata)
   );

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and address split
   ////////////////////////////////////////////////////////////
   localparam int ADDR_W     = 16;                        // Byte address
   localparam int DATA_W     = 32;                        // One word per line
   localparam int STRB_W     = DATA_W / 8;                // Byte strobes per word
   localparam int BYTE_OFF_W = 2;
   localparam int L1_IDX_W   = 3;                         // 8 lines
   localparam int L2_IDX_W   = 5;                         // 32 lines
   localparam int L1_TAG_W   = ADDR_W - L1_IDX_W - BYTE_OFF_W;
   localparam int L2_TAG_W   = ADDR_W - L2_IDX_W - BYTE_OFF_W;

   ////////////////////////////////////////////////////////////
   // Request and line entries
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;                           // Zero means read
   } cache_req_t;

   typedef struct packed {
      logic [L1_TAG_W-1:0] tag;
      logic [DATA_W-1:0]   data;
   } l1_entry_t;

   typedef struct packed {
      logic [L2_TAG_W-1:0] tag;
      logic [DATA_W-1:0]   data;
   } l2_entry_t;

   // Controller states shared by both levels
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,                                          // Line store read
      ST_COMPARE,                                         // Tag check
      ST_DOWN,                                            // Waiting on next level
      ST_DONE                                             // Ready pulse
   } cache_state_t;

   function automatic logic [L1_IDX_W-1:0] l1_idx(input logic [ADDR_W-1:0] addr);
      return addr[BYTE_OFF_W +: L1_IDX_W];
   endfunction

   function automatic logic [L1_TAG_W-1:0] l1_tag(input logic [ADDR_W-1:0] addr);
      return addr[ADDR_W-1 -: L1_TAG_W];
   endfunction

   function automatic logic [L2_IDX_W-1:0] l2_idx(input logic [ADDR_W-1:0] addr);
      return addr[BYTE_OFF_W +: L2_IDX_W];
   endfunction

   function automatic logic [L2_TAG_W-1:0] l2_tag(input logic [ADDR_W-1:0] addr);
      return addr[ADDR_W-1 -: L2_TAG_W];
   endfunction

   // Byte-wise merge of a write into a stored word
   function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < STRB_W; b++)
      begin
         if (strb[b])
         begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

// ==== src/l1_arbiter.sv ====
`timescale 1ns/1ps

module l1_arbiter
   import cache_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   // Instruction L1 miss port
   input  logic       i_i_valid,
   input  cache_req_t i_i_req,
   output logic       o_i_ready,
   // Data L1 miss port
   input  logic       i_d_valid,
   input  cache_req_t i_d_req,
   output logic       o_d_ready,
   // Shared L2 port
   output logic       o_l2_valid,
   output cache_req_t o_l2_req,
   input  logic       i_l2_ready
);

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_I,
      OWN_D
   } owner_t;

   owner_t owner_q;
   owner_t owner_d;
   logic   done_q;                                        // L2 completed last cycle

   ////////////////////////////////////////////////////////////
   // Grant held until the L2 ready
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      owner_d = owner_q;
      case (owner_q)
         OWN_NONE:
         begin
            if (i_i_valid)
            begin
               owner_d = OWN_I;                           // Instruction side first
            end
            else if (i_d_valid)
            begin
               owner_d = OWN_D;
            end
         end
         OWN_I:   if (i_l2_ready) owner_d = i_d_valid ? OWN_D : OWN_NONE; // Hand over if waiting
         OWN_D:   if (i_l2_ready) owner_d = i_i_valid ? OWN_I : OWN_NONE;
         default: owner_d = OWN_NONE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         owner_q <= OWN_NONE;
         done_q  <= 1'b0;
      end
      else
      begin
         owner_q <= owner_d;
         done_q  <= i_l2_ready;
      end
   end

   // Masked after completion so L2 sees a fresh request
   assign o_l2_valid = !done_q && (((owner_q == OWN_I) && i_i_valid) ||
                                   ((owner_q == OWN_D) && i_d_valid));
   assign o_l2_req   = (owner_q == OWN_D) ? i_d_req : i_i_req;
   assign o_i_ready  = i_l2_ready && (owner_q == OWN_I);
   assign o_d_ready  = i_l2_ready && (owner_q == OWN_D);

endmodule

// ==== src/l1_cache.sv ====
`timescale 1ns/1ps

module l1_cache
   import cache_pkg::*;
#(
   parameter bit IS_INSTR = 1'b0                          // 1 on the instruction side
)
(
   input  logic              clk,
   input  logic              i_rst_n,
   // Processor side
   input  logic              i_valid,
   input  cache_req_t        i_req,
   output logic              o_ready,
   output logic [DATA_W-1:0] o_rdata,
   // Toward L2 through the arbiter
   output logic              o_mem_valid,
   output cache_req_t        o_mem_req,
   input  logic              i_mem_ready,
   input  logic [DATA_W-1:0] i_mem_rdata
);

   cache_state_t        state_q;
   cache_state_t        state_d;
   l1_entry_t           rd_entry;
   logic                rd_valid;
   logic                wr_en;
   l1_entry_t           wr_entry;
   logic [L1_IDX_W-1:0] idx;
   logic [L1_TAG_W-1:0] tag;
   logic                is_write;
   logic                hit;
   logic [DATA_W-1:0]   rdata_q;                         // Word returned with ready

   assign idx      = l1_idx(i_req.addr);                  // Request is held, so index is stable
   assign tag      = l1_tag(i_req.addr);
   assign is_write = |i_req.wstrb;
   assign hit      = rd_valid && (rd_entry.tag == tag);

   line_store #(
      .T_ENTRY (l1_entry_t),
      .IDX_W   (L1_IDX_W)
   ) u_store (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rd_idx   (idx),
      .o_rd_entry (rd_entry),
      .o_rd_valid (rd_valid),
      .i_wr_en    (wr_en),
      .i_wr_idx   (idx),
      .i_wr_entry (wr_entry)
   );

   ////////////////////////////////////////////////////////////
   // Controller FSM
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:    state_d = i_valid ? ST_LOOKUP : ST_IDLE;
         ST_LOOKUP:  state_d = ST_COMPARE;
         ST_COMPARE: state_d = (hit && !is_write) ? ST_DONE : ST_DOWN; // Writes always go down
         ST_DOWN:    state_d = i_mem_ready ? ST_DONE : ST_DOWN;
         ST_DONE:    state_d = ST_IDLE;                   // Master drops valid here
         default:    state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         state_q <= ST_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Strobe merge on write hit and fill on read miss
   always_comb
   begin
      wr_en         = 1'b0;
      wr_entry.tag  = tag;
      wr_entry.data = i_mem_rdata;                        // Fill word
      if ((state_q == ST_COMPARE) && hit && is_write)
      begin
         wr_en         = 1'b1;
         wr_entry.data = strb_merge(rd_entry.data, i_req.wdata, i_req.wstrb);
      end
      else if ((state_q == ST_DOWN) && i_mem_ready && !is_write)
      begin
         wr_en = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == ST_COMPARE)
      begin
         rdata_q <= rd_entry.data;                        // Hit data
      end
      else if ((state_q == ST_DOWN) && i_mem_ready)
      begin
         rdata_q <= i_mem_rdata;                          // Miss data
      end
   end

   assign o_ready     = (state_q == ST_DONE);
   assign o_rdata     = rdata_q;
   assign o_mem_valid = (state_q == ST_DOWN);
   assign o_mem_req   = i_req;                            // Forwarded unchanged

   // Request held steady until the ready pulse
   a_req_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_valid && !o_ready) |=> (i_valid && $stable(i_req)))
      else $error("%s L1: request changed before ready", IS_INSTR ? "instr" : "data");

   // Arbiter only passes L2 ready to the side that is waiting
   a_mem_owner : assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_ready |-> o_mem_valid)
      else $error("%s L1: downstream ready without request", IS_INSTR ? "instr" : "data");

endmodule

// ==== src/l2_cache.sv ====
`timescale 1ns/1ps

module l2_cache
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   // From the arbiter
   input  logic              i_valid,
   input  cache_req_t        i_req,
   output logic              o_ready,
   output logic [DATA_W-1:0] o_rdata,
   // Native memory port
   output logic              o_mem_valid,
   output cache_req_t        o_mem_req,
   input  logic              i_mem_ready,
   input  logic [DATA_W-1:0] i_mem_rdata
);

   cache_state_t        state_q;
   cache_state_t        state_d;
   l2_entry_t           rd_entry;
   logic                rd_valid;
   logic                wr_en;
   l2_entry_t           wr_entry;
   logic [L2_IDX_W-1:0] idx;
   logic [L2_TAG_W-1:0] tag;
   logic                is_write;
   logic                hit;
   logic [DATA_W-1:0]   rdata_q;

   assign idx      = l2_idx(i_req.addr);
   assign tag      = l2_tag(i_req.addr);
   assign is_write = |i_req.wstrb;                        // Zero strobes is a read
   assign hit      = rd_valid && (rd_entry.tag == tag);

   line_store #(
      .T_ENTRY (l2_entry_t),
      .IDX_W   (L2_IDX_W)
   ) u_store (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rd_idx   (idx),
      .o_rd_entry (rd_entry),
      .o_rd_valid (rd_valid),
      .i_wr_en    (wr_en),
      .i_wr_idx   (idx),
      .i_wr_entry (wr_entry)
   );

   ////////////////////////////////////////////////////////////
   // Controller FSM
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:    state_d = i_valid ? ST_LOOKUP : ST_IDLE;
         ST_LOOKUP:  state_d = ST_COMPARE;
         ST_COMPARE: state_d = (hit && !is_write) ? ST_DONE : ST_DOWN;
         ST_DOWN:    state_d = i_mem_ready ? ST_DONE : ST_DOWN; // Memory delay varies
         ST_DONE:    state_d = ST_IDLE;
         default:    state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         state_q <= ST_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Write hit merges under strobes, read miss fills from memory
   always_comb
   begin
      wr_en         = 1'b0;
      wr_entry.tag  = tag;
      wr_entry.data = i_mem_rdata;
      if ((state_q == ST_COMPARE) && hit && is_write)
      begin
         wr_en         = 1'b1;
         wr_entry.data = strb_merge(rd_entry.data, i_req.wdata, i_req.wstrb);
      end
      else if ((state_q == ST_DOWN) && i_mem_ready && !is_write)
      begin
         wr_en = 1'b1;                                    // No allocate on write miss
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == ST_COMPARE)
      begin
         rdata_q <= rd_entry.data;
      end
      else if ((state_q == ST_DOWN) && i_mem_ready)
      begin
         rdata_q <= i_mem_rdata;
      end
   end

   assign o_ready     = (state_q == ST_DONE);             // One-cycle pulse
   assign o_rdata     = rdata_q;
   assign o_mem_valid = (state_q == ST_DOWN);
   assign o_mem_req   = i_req;

   // Arbiter must keep the granted request steady
   a_req_stable : assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_valid && !o_ready) |=> (i_valid && $stable(i_req)))
      else $error("L2: request changed before ready");

endmodule

// ==== src/line_store.sv ====
`timescale 1ns/1ps

module line_store
#(
   parameter type T_ENTRY = logic [31:0],                 // Tag plus data word
   parameter int  IDX_W   = 3                             // log2 of line count
)
(
   input  logic             clk,
   input  logic             i_rst_n,
   input  logic [IDX_W-1:0] i_rd_idx,
   output T_ENTRY           o_rd_entry,                   // One cycle after i_rd_idx
   output logic             o_rd_valid,
   input  logic             i_wr_en,
   input  logic [IDX_W-1:0] i_wr_idx,
   input  T_ENTRY           i_wr_entry
);

   T_ENTRY                entries [0:(1<<IDX_W)-1];
   logic [(1<<IDX_W)-1:0] line_vld;                      // One bit per line
   logic                  bypass;                        // Read hits the line being written

   assign bypass = i_wr_en && (i_wr_idx == i_rd_idx);

   ////////////////////////////////////////////////////////////
   // Entry array with registered read
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (i_wr_en)
      begin
         entries[i_wr_idx] <= i_wr_entry;
      end
      o_rd_entry <= bypass ? i_wr_entry : entries[i_rd_idx]; // New entry wins
   end

   // Valid bits cleared on reset
   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         line_vld   <= '0;
         o_rd_valid <= 1'b0;
      end
      else
      begin
         if (i_wr_en)
         begin
            line_vld[i_wr_idx] <= 1'b1;                   // Any write fills the line
         end
         o_rd_valid <= bypass | line_vld[i_rd_idx];
      end
   end

endmodule

// ==== verif/cache_hier_tb.sv ====
`timescale 1ns/1ps

module cache_hier_tb
   import cache_pkg::*;
();

   localparam int    CLK_PER_NS = 100;
   localparam int    RST_CYCLES = 5;
   localparam int    MAX_VEC    = 64;
   localparam int    VEC_CYCLES = 40;                     // Watchdog budget per vector
   localparam string DATA_FILE  = "verif/cache_hier_testdata.txt";

   logic              clk = 1'b0;
   logic              rst_n;
   logic              valid;
   logic              instr;
   cache_req_t        req;
   logic              ready;
   logic [DATA_W-1:0] rdata;
   logic              mem_valid;
   cache_req_t        mem_req;
   logic              mem_ready;
   logic [DATA_W-1:0] mem_rdata;
   int                mem_count;
   cache_req_t        mem_last_req;

   // Vectors from the data file
   string             vec_name  [MAX_VEC];
   logic              vec_instr [MAX_VEC];
   logic [ADDR_W-1:0] vec_addr  [MAX_VEC];
   logic [DATA_W-1:0] vec_wdata [MAX_VEC];
   logic [STRB_W-1:0] vec_strb  [MAX_VEC];
   logic [DATA_W-1:0] vec_rdata [MAX_VEC];
   int                vec_mem   [MAX_VEC];
   int                n_vec;
   bit                loaded;
   int                errors;                             // Value and file errors
   int                proto_errors;                       // Handshake monitor

   always #(CLK_PER_NS/2) clk = ~clk;

   cache_hier dut0 (
      .clk         (clk),
      .i_rst_n     (rst_n),
      .i_valid     (valid),
      .i_instr     (instr),
      .i_req       (req),
      .o_ready     (ready),
      .o_rdata     (rdata),
      .o_mem_valid (mem_valid),
      .o_mem_req   (mem_req),
      .i_mem_ready (mem_ready),
      .i_mem_rdata (mem_rdata)
   );

   mem_model u_mem (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .i_valid    (mem_valid),
      .i_req      (mem_req),
      .o_ready    (mem_ready),
      .o_rdata    (mem_rdata),
      .o_count    (mem_count),
      .o_last_req (mem_last_req)
   );

   ////////////////////////////////////////////////////////////
   // Data file reader
   ////////////////////////////////////////////////////////////
   task automatic load_vectors();
      int          fd;
      int          r;
      string       tok;
      string       rest;
      logic [31:0] f_instr;
      logic [31:0] f_addr;
      logic [31:0] f_wdata;
      logic [31:0] f_strb;
      logic [31:0] f_rdata;
      int          f_mem;
      n_vec = 0;
      fd    = $fopen(DATA_FILE, "r");
      if (fd == 0)
      begin
         $display("Cannot open the test data file %s", DATA_FILE);
         errors++;
         return;
      end
      while (n_vec < MAX_VEC)
      begin
         r = $fscanf(fd, "%s", tok);                      // Test name or comment mark
         if (r != 1)
         begin
            break;
         end
         if (tok[0] == "#")
         begin
            r = $fgets(rest, fd);                         // Skip header text
         end
         else
         begin
            r = $fscanf(fd, "%h %h %h %h %h %d", f_instr, f_addr, f_wdata, f_strb,
                        f_rdata, f_mem);
            if (r != 6)
            begin
               $display("Test data line for %s could not be parsed", tok);
               errors++;
               break;
            end
            vec_name[n_vec]  = tok;
            vec_instr[n_vec] = f_instr[0];
            vec_addr[n_vec]  = f_addr[ADDR_W-1:0];
            vec_wdata[n_vec] = f_wdata;
            vec_strb[n_vec]  = f_strb[STRB_W-1:0];
            vec_rdata[n_vec] = f_rdata;
            vec_mem[n_vec]   = f_mem;
            n_vec++;
         end
      end
      $fclose(fd);
   endtask

   // Nothing may move between reset and the first request
   task automatic check_quiet(input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         assert (!ready && !mem_valid && (mem_count == 0))
         else
         begin
            $display("Ready or memory traffic seen after reset before any request");
            errors++;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // One processor access held until ready
   ////////////////////////////////////////////////////////////
   task automatic run_access(input int v);
      cache_req_t        sent;
      int                count_before;
      int                accesses;
      logic [DATA_W-1:0] got_rdata;
      sent.addr    = vec_addr[v];
      sent.wdata   = vec_wdata[v];
      sent.wstrb   = vec_strb[v];
      count_before = mem_count;                           // Memory is idle here
      instr <= vec_instr[v];
      req   <= sent;
      valid <= 1'b1;
      do
      begin
         @(posedge clk);
      end
      while (!ready);
      got_rdata = rdata;                                  // Ready cycle values
      accesses  = mem_count - count_before;
      valid <= 1'b0;
      if (sent.wstrb == '0)
      begin
         assert (got_rdata === vec_rdata[v])
         else
         begin
            $display("ERROR %s: rdata expected %h, got %h", vec_name[v], vec_rdata[v],
                     got_rdata);
            errors++;
         end
      end
      else
      begin
         assert (mem_last_req === sent)                   // Write passes through unchanged
         else
         begin
            $display("ERROR %s: memory request expected %h, got %h", vec_name[v], sent,
                     mem_last_req);
            errors++;
         end
      end
      assert (accesses == vec_mem[v])
      else
      begin
         $display("ERROR %s: memory accesses expected %0d, got %0d", vec_name[v], vec_mem[v],
                  accesses);
         errors++;
      end
      @(posedge clk);                                     // Idle cycle between requests
   endtask

   // Ready only ever answers a pending request
   always @(posedge clk)
   begin
      if (rst_n === 1'b1)
      begin
         assert (!ready || valid)
         else
         begin
            $display("Ready pulse seen with no request pending");
            proto_errors++;
         end
      end
   end

   initial
   begin
      rst_n        = 1'b0;
      valid        = 1'b0;
      instr        = 1'b0;
      req          = '0;
      errors       = 0;
      proto_errors = 0;
      loaded       = 1'b0;
      load_vectors();
      loaded = 1'b1;
      if (n_vec == 0)
      begin
         $display("No test vectors were read");
         errors++;
      end
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      check_quiet(4);
      for (int v = 0; v < n_vec; v++)
      begin
         run_access(v);
      end
      $display("Vectors %0d, value errors %0d, protocol errors %0d", n_vec, errors,
               proto_errors);
      if ((errors == 0) && (proto_errors == 0))
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

   // Watchdog sized from the vector count
   initial
   begin
      wait (loaded);
      #((n_vec * VEC_CYCLES + RST_CYCLES + 8) * CLK_PER_NS);
      $display("Timeout: run did not finish, value errors %0d, protocol errors %0d",
               errors, proto_errors);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== verif/cache_hier_testdata.txt ====
# name instr addr wdata wstrb exp_rdata exp_mem
# All fields hex except exp_mem and exp_rdata is unused for writes
wr_a          0 0100 11223344 f 00000000 1
wr_a_part     0 0100 aabbccdd 5 00000000 1
rd_a_miss     0 0100 00000000 0 11bb33dd 1
rd_a_hit      0 0100 00000000 0 11bb33dd 0
wr_b          0 0180 cafef00d f 00000000 1
rd_b_conflict 0 0180 00000000 0 cafef00d 1
rd_a_evicted  0 0100 00000000 0 11bb33dd 1
wr_a_top      0 0100 77000000 8 00000000 1
rd_a_merged   0 0100 00000000 0 77bb33dd 0
if_a_l2hit    1 0100 00000000 0 77bb33dd 0
if_a_l1hit    1 0100 00000000 0 77bb33dd 0
wr_c          0 0204 01020304 f 00000000 1
wr_d          0 0224 a5a5f00f f 00000000 1
rd_c_fill     0 0204 00000000 0 01020304 1
rd_d_fill     0 0224 00000000 0 a5a5f00f 1
rd_c_l2       0 0204 00000000 0 01020304 0
rd_d_l2       0 0224 00000000 0 a5a5f00f 0
rd_c_l2b      0 0204 00000000 0 01020304 0
wr_e          0 0308 deadbeef f 00000000 1
if_e_miss     1 0308 00000000 0 deadbeef 1
rd_e_l2       0 0308 00000000 0 deadbeef 0
wr_e_lo       0 0308 0000cafe 3 00000000 1
rd_e_lo       0 0308 00000000 0 deadcafe 0

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps

module mem_model
   import cache_pkg::*;
(
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_valid,
   input  cache_req_t        i_req,
   output logic              o_ready,
   output logic [DATA_W-1:0] o_rdata,
   output int                o_count,                     // Completed accesses
   output cache_req_t        o_last_req                   // Last request that completed
);

   localparam int WORDS = 1 << (ADDR_W - BYTE_OFF_W);

   logic [DATA_W-1:0]            words [0:WORDS-1];
   logic [ADDR_W-BYTE_OFF_W-1:0] widx;
   logic [DATA_W-1:0]            merged;
   logic                         ready_q = 1'b0;          // Ready pulse
   logic [DATA_W-1:0]            rdata_q = '0;
   logic                         busy;
   int                           delay;
   integer                       seed = 32'h06cd_ac6f;

   assign widx    = i_req.addr[ADDR_W-1:BYTE_OFF_W];
   assign o_ready = ready_q;
   assign o_rdata = rdata_q;

   ////////////////////////////////////////////////////////////
   // Native port with ready 1 to 4 cycles after valid
   ////////////////////////////////////////////////////////////
   always @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         for (int i = 0; i < WORDS; i++)
         begin
            words[i] <= '0;                               // Memory starts at zero
         end
         ready_q    <= 1'b0;
         busy       <= 1'b0;
         delay      <= 0;
         o_count    <= 0;
         o_last_req <= '0;
      end
      else if (ready_q)
      begin
         ready_q <= 1'b0;                                 // One-cycle pulse
      end
      else if (i_valid && !busy)
      begin
         busy  <= 1'b1;
         delay <= $unsigned($random(seed)) % 4;           // Extra wait cycles
      end
      else if (busy && (delay > 0))
      begin
         delay <= delay - 1;
      end
      else if (busy)
      begin
         merged = words[widx];
         for (int b = 0; b < STRB_W; b++)
         begin
            if (i_req.wstrb[b])
            begin
               merged[8*b +: 8] = i_req.wdata[8*b +: 8];  // Byte lane write
            end
         end
         words[widx] <= merged;
         rdata_q     <= words[widx];                      // Read returns the old word
         ready_q     <= 1'b1;
         busy        <= 1'b0;
         o_count     <= o_count + 1;
         o_last_req  <= i_req;
      end
   end

endmodule
